// ==== common/x86_isa_pkg.sv ====
`default_nettype none

package x86_isa_pkg;

	// first byte of the instruction, one entry per supported class
	// push/pop keep the base of their 8-opcode range
	typedef enum logic [7:0] {
		UNSUPPORTED = 8'h0f, // anything the decoder does not know
		PUSH_R      = 8'h50, // 50..57
		POP_R       = 8'h58, // 58..5f
		PUSH_IMM8   = 8'h6a,
		JNE_REL8    = 8'h75,
		GRP1_IMM8   = 8'h83, // add/sub r/m32, imm8
		MOV_RM_R    = 8'h89,
		MOV_R_RM    = 8'h8b,
		MOV_EAX_IMM = 8'hb8,
		RET         = 8'hc3,
		LEAVE       = 8'hc9,
		CALL_REL    = 8'he8,
		JMP_REL8    = 8'heb
	} opcode_e;

	// reg field of modrm for opcode 83
	typedef enum logic [2:0] {
		ADD = 3'd0,
		SUB = 3'd5
	} grp1_e;

	// register numbering as encoded in modrm and low opcode bits
	typedef enum logic [2:0] {
		EAX, ECX, EDX, EBX, ESP, EBP, ESI, EDI
	} gpr_e;

	// mod field of modrm
	localparam logic [1:0] MOD_DISP8 = 2'b01; // [r/m + disp8]
	localparam logic [1:0] MOD_REG   = 2'b11; // register direct

endpackage

`default_nettype wire

// ==== common/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

	localparam logic [31:0] STACK_WORD = 32'd4;     // bytes per push
	localparam int          STACK_DEPTH = 64;       // words in the stack window
	localparam int          STACK_AW = $clog2(STACK_DEPTH);
	localparam logic [31:0] ESP_RESET = 32'h0000_0100; // top of stack window
	localparam logic [31:0] EIP_RESET = 32'h0000_0000;

	// where the sequencer stands inside an instruction
	typedef enum logic [2:0] {
		IDLE,
		STEP1,
		STEP2,
		STEP3,
		FINISH // done strobe cycle
	} step_e;

	// what the current step writes
	typedef enum logic [1:0] {
		DEST_NONE,
		DEST_GPR,
		DEST_EIP,
		DEST_MEM
	} dest_e;

endpackage

`default_nettype wire

// ==== common/exec_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// per-step bundle between sequencer, decoder, alu and register file
interface exec_if import exec_pkg::*, x86_isa_pkg::*; ();
	step_e       step;      // current step
	opcode_e     opcode;    // class of held insn
	grp1_e       sub;       // 83 sub-op
	gpr_e        dst_sel;
	gpr_e        src_sel;
	logic [31:0] src_val;   // reg[src_sel]
	logic [31:0] frame_val; // ebp
	logic [31:0] esp_val;
	logic [31:0] eip_val;
	logic [31:0] mem_rdata; // stack word at mem_addr
	logic [31:0] result;
	dest_e       dest;
	gpr_e        wr_sel;
	logic        eip_adv;   // step also moves eip to eip_next
	logic [31:0] eip_next;  // eip + insn length

	modport seq (output step, output opcode);
	modport alu (
		input step, opcode, sub, dst_sel, src_val, frame_val, esp_val, eip_val, mem_rdata,
		output result, dest, wr_sel, eip_adv, eip_next
	);
	modport rf (
		input src_sel, result, dest, wr_sel, eip_adv, eip_next,
		output src_val, frame_val, esp_val, eip_val
	);
endinterface

`default_nettype wire

// ==== exec_core/insn_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module insn_decoder import x86_isa_pkg::*; (
	input  wire logic [31:0] held_word,
	output opcode_e          opcode,
	output grp1_e            sub,
	output gpr_e             dst_sel,
	output gpr_e             src_sel,
	output logic [1:0]       step_count,
	output logic             unknown
);
	logic [7:0] op_byte;
	logic [1:0] modrm_mod;
	logic [2:0] modrm_reg;
	logic [2:0] modrm_rm;

	assign op_byte   = held_word[31:24];
	assign modrm_mod = held_word[23:22]; // modrm sits right under the opcode
	assign modrm_reg = held_word[21:19];
	assign modrm_rm  = held_word[18:16];

	always_comb begin
		opcode     = UNSUPPORTED;
		sub        = grp1_e'(modrm_reg);
		dst_sel    = gpr_e'(modrm_rm);
		src_sel    = gpr_e'(modrm_reg);
		step_count = 2'd1; // unknown insns are skipped in one step
		case (op_byte) inside
			[8'h50:8'h57]: begin
				opcode     = PUSH_R;
				src_sel    = gpr_e'(op_byte[2:0]); // reg in low opcode bits
				step_count = 2'd2;
			end
			[8'h58:8'h5f]: begin
				opcode     = POP_R;
				dst_sel    = gpr_e'(op_byte[2:0]);
				step_count = 2'd2;
			end
			8'h89: begin
				if (modrm_mod == MOD_REG)
					opcode = MOV_RM_R; // mov rm, reg
			end
			8'h8b: begin
				dst_sel = gpr_e'(modrm_reg); // mov reg, rm
				src_sel = gpr_e'(modrm_rm);
				if (modrm_mod == MOD_REG || (modrm_mod == MOD_DISP8 && modrm_rm == EBP)) begin
					opcode     = MOV_R_RM;
					step_count = 2'd2;
				end
			end
			8'hb8: begin
				opcode  = MOV_EAX_IMM;
				dst_sel = EAX;
			end
			8'h83: begin
				src_sel = gpr_e'(modrm_rm); // read-modify-write of rm
				if (modrm_mod == MOD_REG && (modrm_reg == ADD || modrm_reg == SUB))
					opcode = GRP1_IMM8;
			end
			8'he8: begin
				opcode     = CALL_REL;
				step_count = 2'd3;
			end
			8'hc3: begin
				opcode     = RET;
				step_count = 2'd2;
			end
			8'h6a: begin
				opcode     = PUSH_IMM8;
				step_count = 2'd2;
			end
			8'hc9: begin
				opcode     = LEAVE;
				step_count = 2'd3;
			end
			8'h75: opcode = JNE_REL8;
			8'heb: opcode = JMP_REL8;
			default: opcode = UNSUPPORTED;
		endcase
	end

	assign unknown = (opcode == UNSUPPORTED);

endmodule

`default_nettype wire

// ==== exec_core/step_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_sequencer import exec_pkg::*, x86_isa_pkg::*; (
	input  wire logic        clock_4,
	input  wire logic        arst_n,
	input  wire logic        insn_valid,
	input  wire logic [31:0] insn_word,
	input  wire logic [31:0] insn_imm,
	input  wire logic [3:0]  insn_len,
	input  wire logic [1:0]  step_count, // from decoder
	input  wire logic        unknown,
	input  wire opcode_e     opcode,
	output logic             busy,
	output logic             done,
	output logic             bad_opcode,
	output logic [31:0]      held_word,
	output logic [31:0]      held_imm,
	output logic [3:0]       held_len,
	exec_if.seq              x
);
	step_e state;
	step_e state_nx;
	logic  accept;

	assign busy   = (state == STEP1) || (state == STEP2) || (state == STEP3);
	assign accept = insn_valid && !busy; // strobes during busy are dropped

	// insn payload, no reset needed
	always_ff @(posedge clock_4) begin
		if (accept) begin
			held_word <= insn_word;
			held_imm  <= insn_imm;
			held_len  <= insn_len;
		end
	end

	always_comb begin
		state_nx = state;
		case (state)
			IDLE, FINISH: state_nx = accept ? STEP1 : IDLE; // back to back ok from FINISH
			STEP1:        state_nx = (step_count == 2'd1) ? FINISH : STEP2;
			STEP2:        state_nx = (step_count == 2'd2) ? FINISH : STEP3;
			STEP3:        state_nx = FINISH;
			default:      state_nx = IDLE;
		endcase
	end

	always_ff @(posedge clock_4 or negedge arst_n) begin
		if (!arst_n)
			state <= IDLE;
		else
			state <= state_nx;
	end

	assign done       = (state == FINISH); // one cycle, FINISH never repeats
	assign bad_opcode = done && unknown;   // held_word still valid here

	assign x.step   = state;
	assign x.opcode = busy ? opcode : UNSUPPORTED; // nothing in flight outside steps

endmodule

`default_nettype wire

// ==== exec_core/step_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_alu import exec_pkg::*, x86_isa_pkg::*; (
	exec_if.alu              x,
	input  wire logic [31:0] held_imm,
	input  wire logic [3:0]  held_len,
	input  wire logic [31:0] held_word,
	input  wire logic        zero_flag,
	output logic [31:0]      mem_addr,
	output logic [31:0]      mem_wdata,
	output logic             mem_we
);
	logic [31:0] imm8_sx;
	logic [31:0] disp8_sx;
	logic [31:0] eip_seq;
	logic        reg_form;

	assign imm8_sx  = {{24{held_imm[7]}}, held_imm[7:0]};
	assign disp8_sx = {{24{held_word[15]}}, held_word[15:8]}; // byte after modrm
	assign eip_seq  = x.eip_val + {28'd0, held_len};         // fall-through address
	assign reg_form = (held_word[23:22] == MOD_REG);

	assign x.eip_next = eip_seq;
	assign mem_wdata  = x.result; // only meaningful with DEST_MEM
	assign mem_we     = (x.dest == DEST_MEM);

	always_comb begin
		x.result  = '0;
		x.dest    = DEST_NONE;
		x.wr_sel  = x.dst_sel;
		x.eip_adv = 1'b0;
		mem_addr  = x.esp_val; // stack top unless told otherwise
		case (x.opcode)
			PUSH_R, PUSH_IMM8: begin
				if (x.step == STEP1) begin
					x.result = x.esp_val - STACK_WORD; // make room first
					x.dest   = DEST_GPR;
					x.wr_sel = ESP;
				end else if (x.step == STEP2) begin
					x.result  = (x.opcode == PUSH_R) ? x.src_val : imm8_sx;
					x.dest    = DEST_MEM; // at the new esp
					x.eip_adv = 1'b1;
				end
			end
			POP_R, RET: begin
				if (x.step == STEP1) begin
					x.result = x.mem_rdata;
					x.dest   = (x.opcode == RET) ? DEST_EIP : DEST_GPR;
				end else if (x.step == STEP2) begin
					x.result  = x.esp_val + STACK_WORD;
					x.dest    = DEST_GPR;
					x.wr_sel  = ESP;
					x.eip_adv = (x.opcode == POP_R); // ret already loaded eip
				end
			end
			CALL_REL: begin
				if (x.step == STEP1) begin
					x.result = x.esp_val - STACK_WORD;
					x.dest   = DEST_GPR;
					x.wr_sel = ESP;
				end else if (x.step == STEP2) begin
					x.result = eip_seq; // return address
					x.dest   = DEST_MEM;
				end else if (x.step == STEP3) begin
					x.result = eip_seq + held_imm; // rel32 from next insn
					x.dest   = DEST_EIP;
				end
			end
			LEAVE: begin
				x.dest = DEST_GPR;
				if (x.step == STEP1) begin
					x.result = x.frame_val; // mov esp, ebp
					x.wr_sel = ESP;
				end else if (x.step == STEP2) begin
					x.result = x.mem_rdata; // pop ebp, load half
					x.wr_sel = EBP;
				end else if (x.step == STEP3) begin
					x.result  = x.esp_val + STACK_WORD;
					x.wr_sel  = ESP;
					x.eip_adv = 1'b1;
				end else begin
					x.dest = DEST_NONE;
				end
			end
			MOV_R_RM: begin
				mem_addr = x.frame_val + disp8_sx; // [ebp+disp8]
				if (x.step == STEP1) begin
					x.result = reg_form ? x.src_val : x.mem_rdata;
					x.dest   = DEST_GPR;
				end else if (x.step == STEP2) begin
					x.eip_adv = 1'b1;
				end
			end
			MOV_RM_R, MOV_EAX_IMM, GRP1_IMM8: begin
				if (x.step == STEP1) begin
					x.dest    = DEST_GPR;
					x.eip_adv = 1'b1;
					if (x.opcode == MOV_RM_R)
						x.result = x.src_val;
					else if (x.opcode == MOV_EAX_IMM)
						x.result = held_imm;
					else if (x.sub == SUB)
						x.result = x.src_val - imm8_sx;
					else
						x.result = x.src_val + imm8_sx;
				end
			end
			JNE_REL8, JMP_REL8: begin
				if (x.step == STEP1) begin
					x.dest = DEST_EIP;
					if (x.opcode == JNE_REL8 && zero_flag)
						x.result = eip_seq; // not taken
					else
						x.result = eip_seq + imm8_sx;
				end
			end
			default: begin
				x.eip_adv = (x.step == STEP1); // unknown insn just skipped
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/arch_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module arch_regfile import exec_pkg::*, x86_isa_pkg::*; (
	input  wire logic clock_4,
	input  wire logic arst_n,
	exec_if.rf        x,
	output logic [31:0] eip_o,
	output logic [31:0] esp_o,
	output logic [31:0] ebp_o,
	output logic [31:0] eax_o,
	output logic [31:0] ebx_o
);
	logic [31:0] gpr [8]; // indexed by gpr_e
	logic [31:0] eip;

	always_ff @(posedge clock_4 or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++)
				gpr[i] <= '0;
			gpr[ESP] <= ESP_RESET; // empty stack
			eip      <= EIP_RESET;
		end else begin
			if (x.dest == DEST_GPR)
				gpr[x.wr_sel] <= x.result;
			if (x.dest == DEST_EIP)
				eip <= x.result; // jump target wins
			else if (x.eip_adv)
				eip <= x.eip_next;
		end
	end

	// read side
	assign x.src_val   = gpr[x.src_sel];
	assign x.frame_val = gpr[EBP];
	assign x.esp_val   = gpr[ESP];
	assign x.eip_val   = eip;

	assign eip_o = eip;
	assign esp_o = gpr[ESP];
	assign ebp_o = gpr[EBP];
	assign eax_o = gpr[EAX];
	assign ebx_o = gpr[EBX];

endmodule

`default_nettype wire

// ==== hw/stack_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module stack_ram import exec_pkg::*; (
	input  wire logic        clock_4,
	input  wire logic        mem_we,
	input  wire logic [31:0] mem_addr,  // byte address
	input  wire logic [31:0] mem_wdata,
	output logic [31:0]      mem_rdata
);
	logic [31:0]         mem [STACK_DEPTH];
	logic [STACK_AW-1:0] word_idx;

	// low two bits select a byte, above the window wraps
	assign word_idx = mem_addr[STACK_AW+1:2];

	always_ff @(posedge clock_4) begin
		if (mem_we)
			mem[word_idx] <= mem_wdata;
	end

	assign mem_rdata = mem[word_idx]; // async read

endmodule

`default_nettype wire

// ==== hw/x86_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module x86_exec_top import x86_isa_pkg::*; (
	input  wire logic        clock_4,
	input  wire logic        arst_n,
	input  wire logic        insn_valid, // one cycle strobe
	input  wire logic [31:0] insn_word,  // opcode in 31:24
	input  wire logic [31:0] insn_imm,
	input  wire logic [3:0]  insn_len,
	input  wire logic        zero_flag,
	output logic             busy,
	output logic             done,
	output logic             bad_opcode,
	output logic [31:0]      eip,
	output logic [31:0]      esp,
	output logic [31:0]      ebp,
	output logic [31:0]      eax,
	output logic [31:0]      ebx
);
	logic [31:0] held_word;
	logic [31:0] held_imm;
	logic [3:0]  held_len;
	logic [1:0]  step_count;
	logic        unknown;
	opcode_e     dec_opcode;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic        mem_we;

	exec_if x ();

	step_sequencer u_seq (
		.clock_4(clock_4), .arst_n(arst_n), .insn_valid(insn_valid),
		.insn_word(insn_word), .insn_imm(insn_imm), .insn_len(insn_len),
		.step_count(step_count), .unknown(unknown), .opcode(dec_opcode),
		.busy(busy), .done(done), .bad_opcode(bad_opcode),
		.held_word(held_word), .held_imm(held_imm), .held_len(held_len), .x(x)
	);

	insn_decoder u_dec (
		.held_word(held_word), .opcode(dec_opcode), .sub(x.sub),
		.dst_sel(x.dst_sel), .src_sel(x.src_sel), .step_count(step_count), .unknown(unknown)
	);

	step_alu u_alu (
		.x(x), .held_imm(held_imm), .held_len(held_len), .held_word(held_word),
		.zero_flag(zero_flag), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we)
	);

	arch_regfile u_rf (
		.clock_4(clock_4), .arst_n(arst_n), .x(x),
		.eip_o(eip), .esp_o(esp), .ebp_o(ebp), .eax_o(eax), .ebx_o(ebx)
	);

	stack_ram u_ram (
		.clock_4(clock_4), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_rdata(x.mem_rdata)
	);

endmodule

`default_nettype wire

// ==== dv/exec_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_checker (
	input  wire logic        clock_4,
	input  wire logic        arst_n,
	input  wire logic        insn_valid,
	input  wire logic        busy,
	input  wire logic        done,
	input  wire logic        bad_opcode,
	input  wire logic [31:0] eip,
	input  wire logic [31:0] esp,
	input  wire logic [31:0] ebp,
	input  wire logic [31:0] eax,
	input  wire logic [31:0] ebx,
	input  wire logic        check_req, // compare state now, no insn
	input  wire logic [1:0]  exp_steps,
	input  wire logic        exp_bad,
	input  wire logic [31:0] exp_eip,
	input  wire logic [31:0] exp_esp,
	input  wire logic [31:0] exp_ebp,
	input  wire logic [31:0] exp_eax,
	input  wire logic [31:0] exp_ebx,
	output int               check_count,
	output int               err_count
);
	logic pending; // strobe taken, done not yet seen
	int   cycles;  // negedges since the strobe
	logic done_q;

	initial begin
		check_count = 0;
		err_count   = 0;
	end

	task automatic compare_word(input string name, input logic [31:0] got,
			input logic [31:0] want);
		check_count++;
		if (got !== want) begin
			err_count++;
			$display("ERR %s: got 0x%08h, expected 0x%08h at %0t", name, got, want, $time);
		end
	endtask

	task automatic compare_state();
		compare_word("eip", eip, exp_eip);
		compare_word("esp", esp, exp_esp);
		compare_word("ebp", ebp, exp_ebp);
		compare_word("eax", eax, exp_eax);
		compare_word("ebx", ebx, exp_ebx);
	endtask

	// sample mid cycle, away from the driving edge
	always @(negedge clock_4) begin
		if (!arst_n) begin
			pending = 1'b0;
			cycles  = 0;
			done_q  = 1'b0;
		end else begin
			if (pending)
				cycles++;
			if (done) begin
				if (!pending) begin
					err_count++;
					$display("done strobe seen with no instruction in flight at %0t", $time);
				end else begin
					// steps plus one cycle from strobe to done
					compare_word("done latency", 32'(cycles), {30'd0, exp_steps} + 32'd1);
					compare_word("bad_opcode", {31'd0, bad_opcode}, {31'd0, exp_bad});
					compare_word("busy", {31'd0, busy}, 32'd0); // falls with done
					compare_state();
				end
				pending = 1'b0;
			end
			if (pending)
				compare_word("busy", {31'd0, busy}, 32'd1); // high through every step
			if (bad_opcode && !done) begin
				err_count++;
				$display("bad_opcode strobe came without done at %0t", $time);
			end
			if (done && done_q) begin
				err_count++;
				$display("done stayed high for more than one cycle at %0t", $time);
			end
			if (insn_valid && !busy) begin
				pending = 1'b1; // taken on the next rising edge
				cycles  = 0;
			end
			if (check_req)
				compare_state();
			done_q = done;
		end
	end

endmodule

`default_nettype wire

// ==== dv/tb_x86_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_x86_exec;
	localparam int DONE_TIMEOUT = 40; // cycles allowed per instruction

	logic        clock_4 = 1'b0;
	logic        arst_n;
	logic        insn_valid;
	logic [31:0] insn_word;
	logic [31:0] insn_imm;
	logic [3:0]  insn_len;
	logic        zero_flag;
	logic        busy;
	logic        done;
	logic        bad_opcode;
	logic [31:0] eip;
	logic [31:0] esp;
	logic [31:0] ebp;
	logic [31:0] eax;
	logic [31:0] ebx;

	// expected state handed to the checker
	logic        check_req;
	logic [1:0]  exp_steps;
	logic        exp_bad;
	logic [31:0] exp_eip;
	logic [31:0] exp_esp;
	logic [31:0] exp_ebp;
	logic [31:0] exp_eax;
	logic [31:0] exp_ebx;
	int          check_count;
	int          err_count;
	int          timeouts;
	int          file_errs;
	logic        aborted;

	// one golden line
	logic [31:0] f_mode;
	logic [31:0] f_word;
	logic [31:0] f_imm;
	logic [31:0] f_len;
	logic [31:0] f_zf;
	logic [31:0] f_steps;
	logic [31:0] f_bad;
	logic [31:0] f_eip;
	logic [31:0] f_esp;
	logic [31:0] f_ebp;
	logic [31:0] f_eax;
	logic [31:0] f_ebx;

	always #20 clock_4 = ~clock_4; // 40 ns period

	x86_exec_top uut (
		.clock_4(clock_4), .arst_n(arst_n), .insn_valid(insn_valid),
		.insn_word(insn_word), .insn_imm(insn_imm), .insn_len(insn_len),
		.zero_flag(zero_flag), .busy(busy), .done(done), .bad_opcode(bad_opcode),
		.eip(eip), .esp(esp), .ebp(ebp), .eax(eax), .ebx(ebx)
	);

	exec_checker chk (
		.clock_4(clock_4), .arst_n(arst_n), .insn_valid(insn_valid), .busy(busy),
		.done(done), .bad_opcode(bad_opcode),
		.eip(eip), .esp(esp), .ebp(ebp), .eax(eax), .ebx(ebx),
		.check_req(check_req), .exp_steps(exp_steps), .exp_bad(exp_bad),
		.exp_eip(exp_eip), .exp_esp(exp_esp), .exp_ebp(exp_ebp),
		.exp_eax(exp_eax), .exp_ebx(exp_ebx),
		.check_count(check_count), .err_count(err_count)
	);

	// expected registers from the current line
	task automatic load_expected();
		exp_steps <= f_steps[1:0];
		exp_bad   <= f_bad[0];
		exp_eip   <= f_eip;
		exp_esp   <= f_esp;
		exp_ebp   <= f_ebp;
		exp_eax   <= f_eax;
		exp_ebx   <= f_ebx;
	endtask

	// state compare without an instruction
	task automatic request_check();
		@(posedge clock_4);
		load_expected();
		check_req <= 1'b1;
		@(posedge clock_4);
		check_req <= 1'b0;
	endtask

	// single cycle strobe with payload
	task automatic issue_insn();
		@(posedge clock_4);
		load_expected();
		insn_word  <= f_word;
		insn_imm   <= f_imm;
		insn_len   <= f_len[3:0];
		zero_flag  <= f_zf[0]; // held until the next insn
		insn_valid <= 1'b1;
		@(posedge clock_4);
		insn_valid <= 1'b0;
	endtask

	task automatic wait_done();
		int   n;
		logic seen;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < DONE_TIMEOUT) begin
			@(negedge clock_4); // outputs settled mid cycle
			seen = done;
			n++;
		end
		if (!seen) begin
			$display("timeout: no done within %0d cycles for instruction word 0x%08h",
				DONE_TIMEOUT, f_word);
			timeouts++;
			aborted = 1'b1; // state unknown past this point
		end
	endtask

	initial begin
		int    fd;
		int    n;
		string line;
		logic  eof_seen;
		arst_n     = 1'b0;
		insn_valid = 1'b0;
		insn_word  = '0;
		insn_imm   = '0;
		insn_len   = '0;
		zero_flag  = 1'b0;
		check_req  = 1'b0;
		exp_steps  = '0;
		exp_bad    = 1'b0;
		exp_eip    = '0;
		exp_esp    = '0;
		exp_ebp    = '0;
		exp_eax    = '0;
		exp_ebx    = '0;
		timeouts   = 0;
		file_errs  = 0;
		aborted    = 1'b0;
		eof_seen   = 1'b0;

		repeat (16) @(posedge clock_4);
		arst_n <= 1'b1;

		fd = $fopen("dv/exec_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open the golden file dv/exec_golden.txt");
			file_errs++;
		end else begin
			while (!aborted && !eof_seen) begin
				if ($fgets(line, fd) == 0) begin
					eof_seen = 1'b1;
				end else if (line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
						f_mode, f_word, f_imm, f_len, f_zf, f_steps, f_bad,
						f_eip, f_esp, f_ebp, f_eax, f_ebx);
					if (n != 12) begin
						$display("malformed golden line: %s", line);
						file_errs++;
					end else if (f_mode == 32'd0) begin
						request_check();
					end else begin
						issue_insn();
						wait_done();
					end
				end
			end
			$fclose(fd);
		end

		repeat (2) @(posedge clock_4); // let the last compare land
		$display("checks %0d, errors %0d, timeouts %0d, file problems %0d",
			check_count, err_count, timeouts, file_errs);
		if (err_count == 0 && timeouts == 0 && file_errs == 0 && check_count > 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/exec_golden.txt ====
# mode word imm len zf steps bad | expected eip esp ebp eax ebx, all hex
# mode 0 compares the state only, mode 1 runs one instruction first
0 00000000 00000000 0 0 0 0 00000000 00000100 00000000 00000000 00000000
1 b8000000 12345678 5 0 1 0 00000005 00000100 00000000 12345678 00000000
1 50000000 00000000 1 0 2 0 00000006 000000fc 00000000 12345678 00000000
1 5b000000 00000000 1 0 2 0 00000007 00000100 00000000 12345678 12345678
1 6a800000 00000080 2 0 2 0 00000009 000000fc 00000000 12345678 12345678
1 58000000 00000000 1 0 2 0 0000000a 00000100 00000000 ffffff80 12345678
1 e8000000 00000020 5 0 3 0 0000002f 000000fc 00000000 ffffff80 12345678
1 c3000000 00000000 1 0 2 0 0000000f 00000100 00000000 ffffff80 12345678
1 89dd0000 00000000 2 0 1 0 00000011 00000100 12345678 ffffff80 12345678
1 55000000 00000000 1 0 2 0 00000012 000000fc 12345678 ffffff80 12345678
1 89e50000 00000000 2 0 1 0 00000014 000000fc 000000fc ffffff80 12345678
1 83ec1000 00000010 3 0 1 0 00000017 000000ec 000000fc ffffff80 12345678
1 83c40400 00000004 3 0 1 0 0000001a 000000f0 000000fc ffffff80 12345678
1 b8000000 cafef00d 5 0 1 0 0000001f 000000f0 000000fc cafef00d 12345678
1 50000000 00000000 1 0 2 0 00000020 000000ec 000000fc cafef00d 12345678
1 8b5df000 00000000 3 0 2 0 00000023 000000ec 000000fc cafef00d cafef00d
1 c9000000 00000000 1 0 3 0 00000024 00000100 12345678 cafef00d cafef00d
1 75100000 00000010 2 1 1 0 00000026 00000100 12345678 cafef00d cafef00d
1 75100000 00000010 2 0 1 0 00000038 00000100 12345678 cafef00d cafef00d
1 ebf00000 000000f0 2 0 1 0 0000002a 00000100 12345678 cafef00d cafef00d
1 eb7f0000 0000007f 2 0 1 0 000000ab 00000100 12345678 cafef00d cafef00d
1 0f0b0000 00000000 2 0 1 1 000000ad 00000100 12345678 cafef00d cafef00d
1 f4000000 00000000 1 0 1 1 000000ae 00000100 12345678 cafef00d cafef00d
1 83c80100 00000001 3 0 1 1 000000b1 00000100 12345678 cafef00d cafef00d
1 b8000000 00000001 5 0 1 0 000000b6 00000100 12345678 00000001 cafef00d

// ==== x86_exec.f ====
common/x86_isa_pkg.sv
common/exec_pkg.sv
common/exec_if.sv
exec_core/insn_decoder.sv
exec_core/step_sequencer.sv
exec_core/step_alu.sv
hw/arch_regfile.sv
hw/stack_ram.sv
hw/x86_exec_top.sv
dv/exec_checker.sv
dv/tb_x86_exec.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the x86 execute unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
	--top-module tb_x86_exec \
	-f x86_exec.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

# golden file path is relative to the project root
sim_out=$(./obj_dir/Vtb_x86_exec)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$sim_out" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi

echo "pass message not found in simulation output"
exit 1
